/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_chacha20
FLAGS     ?= --binary --timing
BUILD     ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f project.f --Mdir $(BUILD) -o V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)

/* chacha_core/chacha_quarter_round.sv */
`timescale 1ns/1ps
`include "chacha_consts.svh"

module chacha_quarter_round
    import chacha_data_pkg::*;
(
    input  word_t a_i,
    input  word_t b_i,
    input  word_t c_i,
    input  word_t d_i,
    output word_t a_o,
    output word_t b_o,
    output word_t c_o,
    output word_t d_o
);
    word_t a1;
    word_t b1;
    word_t c1;
    word_t d1;

    function automatic word_t rotl(word_t x, int n);
        return (x << n) | (x >> (`CHACHA_WORD_W - n));
    endfunction

    // First half, rotations 16 and 12
    assign a1 = a_i + b_i;
    assign d1 = rotl(d_i ^ a1, 16);
    assign c1 = c_i + d1;
    assign b1 = rotl(b_i ^ c1, 12);

    // Second half, rotations 8 and 7
    assign a_o = a1 + b1;
    assign d_o = rotl(d1 ^ a_o, 8);
    assign c_o = c1 + d_o;
    assign b_o = rotl(b1 ^ c_o, 7);

endmodule

/* chacha_core/chacha_round_core.sv */
`timescale 1ns/1ps
`include "chacha_consts.svh"

module chacha_round_core
    import chacha_data_pkg::*;
    import chacha_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    seed_if.core    seed,
    block_if.source blk
);
    localparam int ROW_W = 4; // Words per matrix row
    localparam int ROUND_W = $clog2(`CHACHA_DOUBLE_ROUNDS);
    localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(`CHACHA_DOUBLE_ROUNDS - 1);

    core_state_t        state_q;
    logic [ROUND_W-1:0] round_q;
    matrix_t            work_q;  // Working matrix
    matrix_t            init_q;  // Copy for the feed-forward add
    matrix_t            setup_m;
    wire matrix_t       col_m;   // After the column round
    wire matrix_t       dbl_m;   // After the full double round

    // Row 0 constants, rows 1-2 key, row 3 counter then nonce
    always_comb begin
        setup_m[0] = `CHACHA_SIGMA0;
        setup_m[1] = `CHACHA_SIGMA1;
        setup_m[2] = `CHACHA_SIGMA2;
        setup_m[3] = `CHACHA_SIGMA3;
        for (int i = 0; i < `CHACHA_KEY_WORDS; i++) begin
            setup_m[ROW_W + i] = seed.key[i];
        end
        setup_m[3 * ROW_W] = seed.counter;
        for (int i = 0; i < `CHACHA_NONCE_WORDS; i++) begin
            setup_m[3 * ROW_W + 1 + i] = seed.nonce[i];
        end
    end

    // Column g feeds the quarter round, then the diagonal starting at word g
    for (genvar g = 0; g < ROW_W; g++) begin : g_qr
        chacha_quarter_round i_col (
            .a_i (work_q[g]),
            .b_i (work_q[ROW_W + g]),
            .c_i (work_q[2 * ROW_W + g]),
            .d_i (work_q[3 * ROW_W + g]),
            .a_o (col_m[g]),
            .b_o (col_m[ROW_W + g]),
            .c_o (col_m[2 * ROW_W + g]),
            .d_o (col_m[3 * ROW_W + g])
        );

        chacha_quarter_round i_diag (
            .a_i (col_m[g]),
            .b_i (col_m[ROW_W + (g + 1) % ROW_W]),
            .c_i (col_m[2 * ROW_W + (g + 2) % ROW_W]),
            .d_i (col_m[3 * ROW_W + (g + 3) % ROW_W]),
            .a_o (dbl_m[g]),
            .b_o (dbl_m[ROW_W + (g + 1) % ROW_W]),
            .c_o (dbl_m[2 * ROW_W + (g + 2) % ROW_W]),
            .d_o (dbl_m[3 * ROW_W + (g + 3) % ROW_W])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= CORE_IDLE;
            round_q <= '0;
        end else begin
            case (state_q)
                CORE_IDLE: begin
                    if (seed.load) begin
                        state_q <= CORE_SETUP;
                    end
                end
                CORE_SETUP: begin
                    state_q <= CORE_ROUNDS;
                    round_q <= '0;
                end
                CORE_ROUNDS: begin
                    if (round_q == LAST_ROUND) begin
                        state_q <= CORE_FINISH;
                    end else begin
                        round_q <= round_q + 1'b1;
                    end
                end
                default: state_q <= CORE_IDLE; // FINISH lasts one cycle
            endcase
        end
    end

    // Both matrices hold after FINISH until the next block
    always_ff @(posedge clk) begin
        if (state_q == CORE_SETUP) begin
            work_q <= setup_m;
            init_q <= setup_m;
        end else if (state_q == CORE_ROUNDS) begin
            work_q <= dbl_m;
        end
    end

    assign blk.final_state = work_q;
    assign blk.init_state  = init_q;
    assign blk.valid       = (state_q == CORE_FINISH);

endmodule

/* common/chacha_consts.svh */
`ifndef CHACHA_CONSTS_SVH
`define CHACHA_CONSTS_SVH

// Width of one state word
`define CHACHA_WORD_W 32

// Words in the 4x4 state matrix
`define CHACHA_NUM_WORDS 16

// Seed layout as it arrives from the random source
`define CHACHA_KEY_WORDS 8
`define CHACHA_NONCE_WORDS 3
`define CHACHA_SEED_WORDS 12

// Ten double rounds give the 20 rounds of ChaCha20
`define CHACHA_DOUBLE_ROUNDS 10

// Row 0 constants, "expand 32-byte k"
`define CHACHA_SIGMA0 32'h61707865
`define CHACHA_SIGMA1 32'h3320646e
`define CHACHA_SIGMA2 32'h79622d32
`define CHACHA_SIGMA3 32'h6b206574

`endif

/* common/chacha_ctrl_pkg.sv */
package chacha_ctrl_pkg;

    // Seed collector, one state per field of the seed
    typedef enum logic [1:0] {
        COL_IDLE,
        COL_KEY,
        COL_NONCE,
        COL_COUNTER
    } collect_state_t;

    // Round core
    typedef enum logic [1:0] {
        CORE_IDLE,   // Waiting for load
        CORE_SETUP,  // Build matrix and initial copy
        CORE_ROUNDS, // One double round per clock
        CORE_FINISH  // Result valid
    } core_state_t;

endpackage

/* common/chacha_data_pkg.sv */
`include "chacha_consts.svh"

package chacha_data_pkg;

    // One state word
    typedef logic [`CHACHA_WORD_W-1:0] word_t;

    // Key as it comes in, word 0 first
    typedef word_t [`CHACHA_KEY_WORDS-1:0] key_t;

    typedef word_t [`CHACHA_NONCE_WORDS-1:0] nonce_t;

    // Row-major 4x4 matrix
    // Index 0 sits in the low 32 bits of the flat 512-bit vector
    typedef word_t [`CHACHA_NUM_WORDS-1:0] matrix_t;

endpackage

/* common/chacha_if.sv */
`timescale 1ns/1ps

// Seed handed from the collector to the round core
interface seed_if
    import chacha_data_pkg::*;
();
    key_t   key;
    nonce_t nonce;
    word_t  counter;
    logic   load;    // One-cycle pulse, seed is stable while high

    modport collector (
        output key,
        output nonce,
        output counter,
        output load
    );

    modport core (
        input key,
        input nonce,
        input counter,
        input load
    );
endinterface

// Permuted block plus the matrix it started from
interface block_if
    import chacha_data_pkg::*;
();
    matrix_t final_state;
    matrix_t init_state;
    logic    valid;       // One-cycle pulse

    modport source (output final_state, output init_state, output valid);
    modport sink (input final_state, input init_state, input valid);
endinterface

/* project.f */
+incdir+common
common/chacha_ctrl_pkg.sv
common/chacha_data_pkg.sv
common/chacha_if.sv
chacha_core/chacha_quarter_round.sv
chacha_core/chacha_round_core.sv
rtl/chacha_seed_collect.sv
rtl/chacha_keystream_out.sv
rtl/chacha20_top.sv
tb/tb_chacha20.sv

/* rtl/chacha20_top.sv */
`timescale 1ns/1ps
`include "chacha_consts.svh"

module chacha20_top (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        start_i,
    input  logic [`CHACHA_WORD_W*`CHACHA_NUM_WORDS-1:0] in_state_i,
    input  logic [`CHACHA_WORD_W-1:0]                   trng_data_i,
    input  logic                                        trng_ready_i,
    output logic                                        trng_request_o,
    output logic                                        busy_o,
    output logic                                        done_o,
    output logic [`CHACHA_WORD_W*`CHACHA_NUM_WORDS-1:0] out_state_o
);
    seed_if  seed ();
    block_if blk ();

    // Word stream into key, nonce and counter
    chacha_seed_collect i_collect (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .trng_data_i    (trng_data_i),
        .trng_ready_i   (trng_ready_i),
        .trng_request_o (trng_request_o),
        .busy_o         (busy_o),
        .done_i         (done_o),
        .seed           (seed.collector)
    );

    chacha_round_core i_core (
        .clk  (clk),
        .rst  (rst),
        .seed (seed.core),
        .blk  (blk.source)
    );

    chacha_keystream_out i_keystream (
        .clk         (clk),
        .rst         (rst),
        .blk         (blk.sink),
        .in_state_i  (in_state_i),
        .out_state_o (out_state_o),
        .done_o      (done_o)
    );

endmodule

/* rtl/chacha_keystream_out.sv */
`timescale 1ns/1ps
`include "chacha_consts.svh"

module chacha_keystream_out
    import chacha_data_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,
    block_if.sink                                       blk,
    input  logic [`CHACHA_WORD_W*`CHACHA_NUM_WORDS-1:0] in_state_i,
    output logic [`CHACHA_WORD_W*`CHACHA_NUM_WORDS-1:0] out_state_o,
    output logic                                        done_o
);
    matrix_t ks; // Keystream block

    // Feed-forward, each word added mod 2^32
    always_comb begin
        for (int i = 0; i < `CHACHA_NUM_WORDS; i++) begin
            ks[i] = blk.final_state[i] + blk.init_state[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_state_o <= '0;
            done_o      <= 1'b0;
        end else begin
            done_o <= blk.valid;
            if (blk.valid) begin
                out_state_o <= ks ^ in_state_i; // Same path for encrypt and decrypt
            end
        end
    end

endmodule

/* rtl/chacha_seed_collect.sv */
`timescale 1ns/1ps
`include "chacha_consts.svh"

module chacha_seed_collect
    import chacha_data_pkg::*;
    import chacha_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  word_t     trng_data_i,
    input  logic      trng_ready_i,
    output logic      trng_request_o,
    output logic      busy_o,
    input  logic      done_i,
    seed_if.collector seed
);
    localparam int IDX_W = $clog2(`CHACHA_KEY_WORDS);
    localparam int NONCE_IDX_W = $clog2(`CHACHA_NONCE_WORDS);
    localparam logic [IDX_W-1:0] LAST_KEY = IDX_W'(`CHACHA_KEY_WORDS - 1);
    localparam logic [IDX_W-1:0] LAST_NONCE = IDX_W'(`CHACHA_NONCE_WORDS - 1);

    collect_state_t   state_q;
    logic [IDX_W-1:0] idx_q;    // Word index inside the current field
    logic             busy_q;
    logic             load_q;
    logic             take;
    logic             start_ok;
    key_t             key_q;
    nonce_t           nonce_q;
    word_t            counter_q;

    assign trng_request_o = (state_q != COL_IDLE);
    assign take = trng_request_o && trng_ready_i; // Word accepted this edge
    assign busy_o = busy_q && !done_i;            // Falls together with done
    assign start_ok = (state_q == COL_IDLE) && start_i && !busy_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= COL_IDLE;
            idx_q   <= '0;
            busy_q  <= 1'b0;
            load_q  <= 1'b0;
        end else begin
            load_q <= 1'b0;
            if (start_ok) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
            case (state_q)
                COL_IDLE: begin
                    if (start_ok) begin
                        state_q <= COL_KEY;
                        idx_q   <= '0;
                    end
                end
                COL_KEY: begin
                    if (take && idx_q == LAST_KEY) begin
                        state_q <= COL_NONCE;
                        idx_q   <= '0;
                    end else if (take) begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                COL_NONCE: begin
                    if (take && idx_q == LAST_NONCE) begin
                        state_q <= COL_COUNTER;
                        idx_q   <= '0;
                    end else if (take) begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                COL_COUNTER: begin
                    if (take) begin
                        state_q <= COL_IDLE; // Busy stays up until done
                        load_q  <= 1'b1;
                    end
                end
                default: state_q <= COL_IDLE;
            endcase
        end
    end

    // Seed fields, held until the next start
    always_ff @(posedge clk) begin
        if (take) begin
            case (state_q)
                COL_KEY:     key_q[idx_q] <= trng_data_i;
                COL_NONCE:   nonce_q[idx_q[NONCE_IDX_W-1:0]] <= trng_data_i;
                COL_COUNTER: counter_q <= trng_data_i;
                default:     ;
            endcase
        end
    end

    assign seed.key     = key_q;
    assign seed.nonce   = nonce_q;
    assign seed.counter = counter_q;
    assign seed.load    = load_q;

endmodule

/* tb/tb_chacha20.sv */
`timescale 1ns/1ps

module tb_chacha20;
    localparam int TEST_COUNT = 5;
    localparam int TEST_CYCLES = 60;  // Longest test with source stalls
    localparam int TIMEOUT_CYCLES = 10 * TEST_COUNT * TEST_CYCLES;
    localparam int LATENCY = 13;      // Last word accepted to done_o

    logic         clk = 1'b0;
    logic         rst;
    logic         start_i;
    logic [511:0] in_state_i;
    logic [31:0]  trng_data_i;
    logic         trng_ready_i;
    logic         trng_request_o;
    logic         busy_o;
    logic         done_o;
    logic [511:0] out_state_o;

    integer       seed = 32'h9783;
    int           errors = 0;
    int           checks = 0;
    int           cycle_cnt = 0;
    logic [31:0]  seed_words [0:11]; // Key words 0 to 7 then nonce 8 to 10 and counter 11
    logic [511:0] msg;
    logic [511:0] result;

    chacha20_top i_chacha20_top (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .in_state_i     (in_state_i),
        .trng_data_i    (trng_data_i),
        .trng_ready_i   (trng_ready_i),
        .trng_request_o (trng_request_o),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .out_state_o    (out_state_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never finished", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] rotate_left(input logic [31:0] x, input int n);
        return (x << n) | (x >> (32 - n));
    endfunction

    function automatic logic [127:0] quarter(input logic [31:0] a_in, b_in, c_in, d_in);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        a = a_in + b_in;
        d = rotate_left(d_in ^ a, 16);
        c = c_in + d;
        b = rotate_left(b_in ^ c, 12);
        a = a + b;
        d = rotate_left(d ^ a, 8);
        c = c + d;
        b = rotate_left(b ^ c, 7);
        return {a, b, c, d};
    endfunction

    // ChaCha20 block from seed_words XORed with the message
    function automatic logic [511:0] block_model(input logic [511:0] msg_in);
        logic [31:0]  s [0:15];
        logic [31:0]  x [0:15];
        logic [511:0] ks;
        s[0] = 32'h61707865; // "expa"
        s[1] = 32'h3320646e; // "nd 3"
        s[2] = 32'h79622d32; // "2-by"
        s[3] = 32'h6b206574; // "te k"
        for (int i = 0; i < 8; i++) begin
            s[4 + i] = seed_words[i];
        end
        s[12] = seed_words[11];
        for (int i = 0; i < 3; i++) begin
            s[13 + i] = seed_words[8 + i];
        end
        x = s;
        for (int r = 0; r < 10; r++) begin
            {x[0], x[4], x[8], x[12]} = quarter(x[0], x[4], x[8], x[12]);
            {x[1], x[5], x[9], x[13]} = quarter(x[1], x[5], x[9], x[13]);
            {x[2], x[6], x[10], x[14]} = quarter(x[2], x[6], x[10], x[14]);
            {x[3], x[7], x[11], x[15]} = quarter(x[3], x[7], x[11], x[15]);
            {x[0], x[5], x[10], x[15]} = quarter(x[0], x[5], x[10], x[15]);
            {x[1], x[6], x[11], x[12]} = quarter(x[1], x[6], x[11], x[12]);
            {x[2], x[7], x[8], x[13]} = quarter(x[2], x[7], x[8], x[13]);
            {x[3], x[4], x[9], x[14]} = quarter(x[3], x[4], x[9], x[14]);
        end
        for (int i = 0; i < 16; i++) begin
            ks[32 * i +: 32] = x[i] + s[i];
        end
        return ks ^ msg_in;
    endfunction

    task automatic randomize_inputs();
        for (int i = 0; i < 12; i++) begin
            seed_words[i] = $random(seed);
        end
        for (int i = 0; i < 16; i++) begin
            msg[32 * i +: 32] = $random(seed);
        end
    endtask

    task automatic expect_block(input string name, input logic [511:0] got,
                                input logic [511:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t: %s out_state_o %h, expected %h", $time, name, got, exp);
        end
    endtask

    // One block from start through the twelve words to done_o
    task automatic run_block(input bit stall, input bit poke, output logic [511:0] got);
        int          ntake;
        int          accept_edge;
        bit          done_seen;
        bit          busy_prev;
        logic [31:0] rnd;
        ntake = 0;
        accept_edge = 0;
        done_seen = 0;
        busy_prev = 0;
        @(posedge clk);
        start_i    <= 1'b1;
        in_state_i <= msg;
        while (!done_seen) begin
            trng_data_i <= seed_words[ntake < 12 ? ntake : 11];
            rnd = $random(seed);
            trng_ready_i <= stall ? rnd[0] : 1'b1;
            @(negedge clk);
            if (ntake == 12 && trng_request_o) begin
                errors++;
                $display("error %0t: trng_request_o high after the twelfth word", $time);
            end else if (trng_request_o && trng_ready_i) begin
                ntake++;
                if (ntake == 12) begin
                    accept_edge = cycle_cnt + 1; // Word taken on the coming edge
                end
            end
            if (done_o) begin
                done_seen = 1;
                checks++;
                if (cycle_cnt - accept_edge != LATENCY || !busy_prev || busy_o) begin
                    errors++;
                    $display("error %0t: done_o after %0d cycles, busy_o %b before, %b now",
                             $time, cycle_cnt - accept_edge, busy_prev, busy_o);
                end
            end
            busy_prev = busy_o;
            got = out_state_o;
            @(posedge clk);
            // Extra start pulses during collection and during the rounds
            start_i <= poke && (ntake == 6 || cycle_cnt == accept_edge + 4);
        end
        start_i <= 1'b0;
        checks++;
        if (ntake != 12) begin
            errors++;
            $display("error %0t: %0d words taken, expected 12", $time, ntake);
        end
        @(negedge clk);
        checks++;
        if (done_o !== 1'b0 || out_state_o !== got) begin
            errors++;
            $display("error %0t: done_o longer than one cycle or output changed", $time);
        end
    endtask

    // Reset at power-up or in the middle of a collection after a finished block
    task automatic reset_outputs(input bit mid_run);
        if (mid_run) begin
            @(posedge clk);
            start_i      <= 1'b1;
            trng_ready_i <= 1'b0; // Request stays high with no word taken
            @(posedge clk);
            start_i <= 1'b0;
            @(posedge clk);
        end
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        if (busy_o !== 1'b0 || done_o !== 1'b0 || trng_request_o !== 1'b0 ||
            out_state_o !== '0) begin
            errors++;
            $display("error %0t: outputs not cleared by reset", $time);
        end
    endtask

    task automatic known_vector();
        for (int i = 0; i < 8; i++) begin
            seed_words[i] = {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)};
        end
        seed_words[8]  = 32'h09000000;
        seed_words[9]  = 32'h4a000000;
        seed_words[10] = 32'h00000000;
        seed_words[11] = 32'h00000001;
        msg = '0;
        run_block(1'b0, 1'b0, result);
        expect_block("known block", result, block_model(msg));
        checks++;
        if (result[31:0] !== 32'he4e7f110) begin // First keystream word of this block
            errors++;
            $display("error %0t: known block word 0 is %h", $time, result[31:0]);
        end
    endtask

    task automatic random_message();
        randomize_inputs();
        run_block(1'b0, 1'b0, result);
        expect_block("random", result, block_model(msg));
    endtask

    task automatic stalled_source();
        randomize_inputs();
        run_block(1'b1, 1'b0, result);
        expect_block("stalled source", result, block_model(msg));
    endtask

    task automatic round_trip();
        logic [511:0] plain;
        randomize_inputs();
        plain = msg;
        run_block(1'b0, 1'b1, result);
        expect_block("encrypt", result, block_model(plain));
        msg = result;
        run_block(1'b1, 1'b1, result);
        expect_block("decrypt", result, plain);
    endtask

    initial begin
        rst          = 1'b1;
        start_i      = 1'b0;
        in_state_i   = '0;
        trng_data_i  = '0;
        trng_ready_i = 1'b0;
        reset_outputs(1'b0);
        known_vector();
        random_message();
        stalled_source();
        round_trip();
        reset_outputs(1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
